/* hdl/tetris_pkg.sv */
package tetris_pkg;

    // board size, row 0 is the top row
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;

    // new pieces enter at row 0 with their box left edge here
    localparam int SPAWN_COL = 3;

    // score saturates here
    localparam int SCORE_MAX = 255;

    // one bit per cell, indexed [row][col]
    typedef logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;

    typedef enum logic [2:0] {
        INIT,
        SPAWN,
        FALLING,
        ROTATE,
        STUCK,
        LANDED,
        EVAL,
        GAMEOVER
    } game_state_t;

    // first seven entries are the spawn orientations, I O S Z J L T
    typedef enum logic [4:0] {
        I_V, O, S_H, Z_H, J_0, L_0, T_0,
        I_H, S_V, Z_V,
        J_90, J_180, J_270,
        L_90, L_180, L_270,
        T_90, T_180, T_270
    } piece_t;

    // 4x4 cell box, indexed [row][col]
    typedef logic [3:0][3:0] pattern_t;

    // top left corner of the piece box on the board
    typedef struct packed {
        logic [4:0] row;
        logic [3:0] col;
    } piece_pos_t;

    // each blocked flag means a move that way hits a wall, the floor or a filled cell
    typedef struct packed {
        logic blocked_left;
        logic blocked_right;
        logic blocked_down;
        logic overlap;
    } fit_t;

    typedef struct packed {
        logic left;
        logic right;
        logic rotate;
        logic start;
    } game_keys_t;

endpackage

/* hdl/key_strobe.sv */
`timescale 1ns/1ps

module key_strobe (
    input  logic clk,
    input  logic reset,
    input  logic level_i,
    output logic strobe_o
);

    logic sync_q0;
    logic sync_q1;
    // last synchronized level, for the edge
    logic prev_q;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync_q0  <= 1'b0;
            sync_q1  <= 1'b0;
            prev_q   <= 1'b0;
            strobe_o <= 1'b0;
        end else begin
            sync_q0  <= level_i;
            sync_q1  <= sync_q0;
            prev_q   <= sync_q1;
            // rising edge only, registered
            strobe_o <= sync_q1 & ~prev_q;
        end
    end

    // a held key must not repeat
    a_single_pulse: assert property (@(posedge clk) disable iff (reset)
        strobe_o |=> !strobe_o);

endmodule

/* hdl/piece_rom.sv */
`timescale 1ns/1ps

module piece_rom (
    input  tetris_pkg::piece_t   piece_i,
    output tetris_pkg::pattern_t pattern_o,
    output tetris_pkg::piece_t   rotated_o
);

    // rows given top to bottom as drawn, leftmost column first
    function automatic tetris_pkg::pattern_t pat(input logic [3:0] r0, input logic [3:0] r1,
                                                 input logic [3:0] r2, input logic [3:0] r3);
        tetris_pkg::pattern_t p;
        // bit reverse so that column 0 lands on bit 0
        p[0] = {<<{r0}};
        p[1] = {<<{r1}};
        p[2] = {<<{r2}};
        p[3] = {<<{r3}};
        return p;
    endfunction

    // patterns sit in the top left corner of the box
    always_comb begin
        case (piece_i)
            tetris_pkg::I_V:   pattern_o = pat(4'b1000, 4'b1000, 4'b1000, 4'b1000);
            tetris_pkg::I_H:   pattern_o = pat(4'b1111, 4'b0000, 4'b0000, 4'b0000);
            tetris_pkg::O:     pattern_o = pat(4'b1100, 4'b1100, 4'b0000, 4'b0000);
            tetris_pkg::S_H:   pattern_o = pat(4'b0110, 4'b1100, 4'b0000, 4'b0000);
            tetris_pkg::S_V:   pattern_o = pat(4'b1000, 4'b1100, 4'b0100, 4'b0000);
            tetris_pkg::Z_H:   pattern_o = pat(4'b1100, 4'b0110, 4'b0000, 4'b0000);
            tetris_pkg::Z_V:   pattern_o = pat(4'b0100, 4'b1100, 4'b1000, 4'b0000);
            tetris_pkg::J_0:   pattern_o = pat(4'b1000, 4'b1110, 4'b0000, 4'b0000);
            tetris_pkg::J_90:  pattern_o = pat(4'b1100, 4'b1000, 4'b1000, 4'b0000);
            tetris_pkg::J_180: pattern_o = pat(4'b1110, 4'b0010, 4'b0000, 4'b0000);
            tetris_pkg::J_270: pattern_o = pat(4'b0100, 4'b0100, 4'b1100, 4'b0000);
            tetris_pkg::L_0:   pattern_o = pat(4'b0010, 4'b1110, 4'b0000, 4'b0000);
            tetris_pkg::L_90:  pattern_o = pat(4'b1000, 4'b1000, 4'b1100, 4'b0000);
            tetris_pkg::L_180: pattern_o = pat(4'b1110, 4'b1000, 4'b0000, 4'b0000);
            tetris_pkg::L_270: pattern_o = pat(4'b1100, 4'b0100, 4'b0100, 4'b0000);
            tetris_pkg::T_0:   pattern_o = pat(4'b0100, 4'b1110, 4'b0000, 4'b0000);
            tetris_pkg::T_90:  pattern_o = pat(4'b1000, 4'b1100, 4'b1000, 4'b0000);
            tetris_pkg::T_180: pattern_o = pat(4'b1110, 4'b0100, 4'b0000, 4'b0000);
            tetris_pkg::T_270: pattern_o = pat(4'b0100, 4'b1100, 4'b0100, 4'b0000);
            default:           pattern_o = '0;
        endcase
    end

    // clockwise rotation cycle
    always_comb begin
        case (piece_i)
            tetris_pkg::I_V:   rotated_o = tetris_pkg::I_H;
            tetris_pkg::I_H:   rotated_o = tetris_pkg::I_V;
            tetris_pkg::S_H:   rotated_o = tetris_pkg::S_V;
            tetris_pkg::S_V:   rotated_o = tetris_pkg::S_H;
            tetris_pkg::Z_H:   rotated_o = tetris_pkg::Z_V;
            tetris_pkg::Z_V:   rotated_o = tetris_pkg::Z_H;
            tetris_pkg::J_0:   rotated_o = tetris_pkg::J_90;
            tetris_pkg::J_90:  rotated_o = tetris_pkg::J_180;
            tetris_pkg::J_180: rotated_o = tetris_pkg::J_270;
            tetris_pkg::J_270: rotated_o = tetris_pkg::J_0;
            tetris_pkg::L_0:   rotated_o = tetris_pkg::L_90;
            tetris_pkg::L_90:  rotated_o = tetris_pkg::L_180;
            tetris_pkg::L_180: rotated_o = tetris_pkg::L_270;
            tetris_pkg::L_270: rotated_o = tetris_pkg::L_0;
            tetris_pkg::T_0:   rotated_o = tetris_pkg::T_90;
            tetris_pkg::T_90:  rotated_o = tetris_pkg::T_180;
            tetris_pkg::T_180: rotated_o = tetris_pkg::T_270;
            tetris_pkg::T_270: rotated_o = tetris_pkg::T_0;
            // O has one orientation
            default:           rotated_o = piece_i;
        endcase
    end

endmodule

/* hdl/piece_fit.sv */
`timescale 1ns/1ps

module piece_fit (
    input  tetris_pkg::board_t     board_i,
    input  tetris_pkg::pattern_t   pattern_i,
    input  tetris_pkg::piece_pos_t pos_i,
    output tetris_pkg::board_t     overlay_o,
    output tetris_pkg::fit_t       fit_o
);

    // true when the cell exists on the board and is empty
    function automatic logic cell_free(input tetris_pkg::board_t b, input int r, input int c);
        if (r < 0 || r >= tetris_pkg::BOARD_ROWS || c < 0 || c >= tetris_pkg::BOARD_COLS) begin
            return 1'b0;
        end
        return !b[5'(r)][4'(c)];
    endfunction

    always_comb begin
        int ar;
        int ac;
        overlay_o = '0;
        fit_o     = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // absolute cell, may run past the right edge or the floor
                ar = int'(pos_i.row) + r;
                ac = int'(pos_i.col) + c;
                if (pattern_i[2'(r)][2'(c)]) begin
                    if (ar < tetris_pkg::BOARD_ROWS && ac < tetris_pkg::BOARD_COLS) begin
                        overlay_o[5'(ar)][4'(ac)] = 1'b1;
                        if (board_i[5'(ar)][4'(ac)]) begin
                            fit_o.overlap = 1'b1;
                        end
                    end else begin
                        // off board counts as a clash
                        fit_o.overlap = 1'b1;
                    end
                    // neighbour cells decide each move
                    if (!cell_free(board_i, ar, ac - 1)) begin
                        fit_o.blocked_left = 1'b1;
                    end
                    if (!cell_free(board_i, ar, ac + 1)) begin
                        fit_o.blocked_right = 1'b1;
                    end
                    if (!cell_free(board_i, ar + 1, ac)) begin
                        fit_o.blocked_down = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hdl/line_clear.sv */
`timescale 1ns/1ps

module line_clear (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_i,
    input  tetris_pkg::board_t board_i,
    output tetris_pkg::board_t board_o,
    output logic               done_o,
    output logic [2:0]         rows_o
);

    typedef enum logic [1:0] {
        LC_IDLE,
        LC_SCAN,
        LC_SHIFT
    } lc_state_t;

    lc_state_t  state;
    // row under test, counts up from the bottom
    logic [4:0] row_idx;
    logic [2:0] row_cnt;
    tetris_pkg::board_t work;
    logic       row_full;

    assign row_full = &work[row_idx];
    assign board_o  = work;
    assign rows_o   = row_cnt;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state   <= LC_IDLE;
            row_idx <= '0;
            row_cnt <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                LC_IDLE: begin
                    if (start_i) begin
                        state   <= LC_SCAN;
                        row_idx <= 5'(tetris_pkg::BOARD_ROWS - 1);
                        row_cnt <= '0;
                    end
                end
                LC_SCAN: begin
                    if (row_full) begin
                        state <= LC_SHIFT;
                    end else if (row_idx == '0) begin
                        // top row checked, result is ready
                        state  <= LC_IDLE;
                        done_o <= 1'b1;
                    end else begin
                        row_idx <= row_idx - 5'd1;
                    end
                end
                LC_SHIFT: begin
                    // same row again, it now holds the row from above
                    state   <= LC_SCAN;
                    row_cnt <= row_cnt + 3'd1;
                end
                default: state <= LC_IDLE;
            endcase
        end
    end

    // working copy of the board
    always_ff @(posedge clk) begin
        if (state == LC_IDLE && start_i) begin
            work <= board_i;
        end else if (state == LC_SHIFT) begin
            for (int k = tetris_pkg::BOARD_ROWS - 1; k > 0; k--) begin
                if (k <= int'(row_idx)) begin
                    work[5'(k)] <= work[5'(k - 1)];
                end
            end
            work[0] <= '0;
        end
    end

    // controller waits for done before the next start
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start_i |-> state == LC_IDLE);

endmodule

/* hdl/tetris_game.sv */
`timescale 1ns/1ps

module tetris_game (
    input  logic               clk,
    input  logic               reset,
    input  logic               left_i,
    input  logic               right_i,
    input  logic               rotate_i,
    input  logic               start_i,
    input  logic               drop_i,
    output tetris_pkg::board_t display_o,
    output logic [7:0]         score_o,
    output logic               gameover_o
);

    tetris_pkg::game_state_t state;
    tetris_pkg::game_state_t next_state;
    tetris_pkg::game_keys_t  keys;
    logic                    drop_stb;

    tetris_pkg::piece_t      piece;
    tetris_pkg::piece_t      rot_piece;
    tetris_pkg::piece_pos_t  pos;
    tetris_pkg::pattern_t    cur_pat;
    tetris_pkg::pattern_t    rot_pat;
    tetris_pkg::board_t      board;
    tetris_pkg::board_t      overlay;
    tetris_pkg::board_t      merged;
    tetris_pkg::fit_t        fit_cur;
    tetris_pkg::fit_t        fit_rot;
    logic [2:0]              spawn_cnt;
    logic [7:0]              score;
    logic [8:0]              score_sum;
    logic                    rotate_take;

    logic                    lc_start;
    logic                    lc_done;
    tetris_pkg::board_t      lc_board;
    logic [2:0]              lc_rows;

    // key levels in, one-cycle strobes out
    key_strobe u_key_left   (.clk(clk), .reset(reset), .level_i(left_i),   .strobe_o(keys.left));
    key_strobe u_key_right  (.clk(clk), .reset(reset), .level_i(right_i),  .strobe_o(keys.right));
    key_strobe u_key_rotate (.clk(clk), .reset(reset), .level_i(rotate_i), .strobe_o(keys.rotate));
    key_strobe u_key_start  (.clk(clk), .reset(reset), .level_i(start_i),  .strobe_o(keys.start));
    key_strobe u_key_drop   (.clk(clk), .reset(reset), .level_i(drop_i),   .strobe_o(drop_stb));

    // current pattern and its clockwise neighbour
    piece_rom u_rom_cur (.piece_i(piece), .pattern_o(cur_pat), .rotated_o(rot_piece));
    piece_rom u_rom_rot (.piece_i(rot_piece), .pattern_o(rot_pat), .rotated_o());

    piece_fit u_fit_cur (
        .board_i(board), .pattern_i(cur_pat), .pos_i(pos),
        .overlay_o(overlay), .fit_o(fit_cur)
    );
    piece_fit u_fit_rot (
        .board_i(board), .pattern_i(rot_pat), .pos_i(pos),
        .overlay_o(), .fit_o(fit_rot)
    );

    line_clear u_line_clear (
        .clk(clk), .reset(reset), .start_i(lc_start), .board_i(board),
        .board_o(lc_board), .done_o(lc_done), .rows_o(lc_rows)
    );

    assign merged      = board | overlay;
    assign rotate_take = keys.rotate && piece != tetris_pkg::O;
    assign score_sum   = {1'b0, score} + 9'(lc_rows);
    assign score_o     = score;
    assign gameover_o  = state == tetris_pkg::GAMEOVER;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= tetris_pkg::INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        lc_start   = 1'b0;
        case (state)
            tetris_pkg::INIT:     if (keys.start) next_state = tetris_pkg::SPAWN;
            tetris_pkg::SPAWN:    next_state = tetris_pkg::FALLING;
            tetris_pkg::FALLING: begin
                // resting on something ends the fall at once
                if (fit_cur.blocked_down) begin
                    next_state = tetris_pkg::STUCK;
                end else if (rotate_take) begin
                    next_state = tetris_pkg::ROTATE;
                end
            end
            tetris_pkg::ROTATE:   next_state = tetris_pkg::FALLING;
            tetris_pkg::STUCK: begin
                next_state = (|merged[0]) ? tetris_pkg::GAMEOVER : tetris_pkg::LANDED;
            end
            tetris_pkg::LANDED: begin
                // single start pulse, board already holds the merge
                lc_start   = 1'b1;
                next_state = tetris_pkg::EVAL;
            end
            tetris_pkg::EVAL:     if (lc_done) next_state = tetris_pkg::SPAWN;
            tetris_pkg::GAMEOVER: next_state = tetris_pkg::GAMEOVER;
            default:              next_state = tetris_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            piece     <= tetris_pkg::I_V;
            pos       <= '{row: 5'd0, col: 4'(tetris_pkg::SPAWN_COL)};
            board     <= '0;
            spawn_cnt <= '0;
            score     <= '0;
        end else begin
            case (state)
                tetris_pkg::SPAWN: begin
                    piece     <= tetris_pkg::piece_t'({2'b00, spawn_cnt});
                    pos       <= '{row: 5'd0, col: 4'(tetris_pkg::SPAWN_COL)};
                    spawn_cnt <= (spawn_cnt == 3'd6) ? 3'd0 : spawn_cnt + 3'd1;
                end
                tetris_pkg::FALLING: begin
                    if (!fit_cur.blocked_down) begin
                        if (rotate_take) begin
                            // in place first, then kick right, then kick left
                            if (!fit_rot.overlap) begin
                                piece <= rot_piece;
                            end else if (!fit_rot.blocked_right) begin
                                piece   <= rot_piece;
                                pos.col <= pos.col + 4'd1;
                            end else if (!fit_rot.blocked_left) begin
                                piece   <= rot_piece;
                                pos.col <= pos.col - 4'd1;
                            end
                        end else if (drop_stb) begin
                            pos.row <= pos.row + 5'd1;
                        end else if (keys.left && !fit_cur.blocked_left) begin
                            pos.col <= pos.col - 4'd1;
                        end else if (keys.right && !fit_cur.blocked_right) begin
                            pos.col <= pos.col + 4'd1;
                        end
                    end
                end
                tetris_pkg::STUCK: board <= merged;
                tetris_pkg::EVAL: begin
                    if (lc_done) begin
                        board <= lc_board;
                        // saturate at the top of the 8-bit score
                        if (score_sum > 9'(tetris_pkg::SCORE_MAX)) begin
                            score <= 8'(tetris_pkg::SCORE_MAX);
                        end else begin
                            score <= score_sum[7:0];
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // piece shown while it is live, stored cells otherwise
    always_comb begin
        case (state)
            tetris_pkg::SPAWN, tetris_pkg::FALLING,
            tetris_pkg::ROTATE, tetris_pkg::STUCK: display_o = merged;
            default:                               display_o = board;
        endcase
    end

    // line clear answers only while the controller waits in EVAL
    a_done_in_eval: assert property (@(posedge clk) disable iff (reset)
        lc_done |-> state == tetris_pkg::EVAL);

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verif/tb_tetris.sv */
`timescale 1ns/1ps

module tb_tetris;

    logic               clk;
    logic               reset;
    logic               left_r;
    logic               right_r;
    logic               rotate_r;
    logic               start_r;
    logic               drop_r;
    tetris_pkg::board_t display;
    logic [7:0]         score;
    logic               gameover;

    // parsed data lines
    string       cmd_q[$];
    int          arg_q[$];
    logic [31:0] exp_q[$];
    int          line_q[$];

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    cycle_limit = 0;
    int    fd;
    int    line_no;
    int    n_fields;
    int    arg;
    logic [31:0] expv;
    string text;
    string cmd;
    string name;

    tb_clock u_clock (.clk(clk), .reset(reset));

    tetris_game u_tetris_game (
        .clk(clk), .reset(reset),
        .left_i(left_r), .right_i(right_r), .rotate_i(rotate_r),
        .start_i(start_r), .drop_i(drop_r),
        .display_o(display), .score_o(score), .gameover_o(gameover)
    );

    // compare one value, report on mismatch
    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error: %s expected %h actual %h", test, expected, actual);
        end
    endtask

    // 0 left, 1 right, 2 rotate, 3 start, 4 drop
    task automatic set_level(input int which, input logic v);
        case (which)
            0: left_r <= v;
            1: right_r <= v;
            2: rotate_r <= v;
            3: start_r <= v;
            default: drop_r <= v;
        endcase
    endtask

    // n presses, 6 cycles high then 6 low
    task automatic pulse(input int which, input int n);
        repeat (n) begin
            @(posedge clk);
            set_level(which, 1'b1);
            repeat (6) @(posedge clk);
            set_level(which, 1'b0);
            repeat (5) @(posedge clk);
        end
    endtask

    // hard stop on runaway
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        left_r   = 1'b0;
        right_r  = 1'b0;
        rotate_r = 1'b0;
        start_r  = 1'b0;
        drop_r   = 1'b0;
        line_no  = 0;
        fd = $fopen("verif/tetris_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the data file verif/tetris_testdata.txt");
            $display("Something failed");
            $finish;
        end else begin
            while ($fgets(text, fd) != 0) begin
                line_no++;
                // skip comments and blank lines
                if (text.len() < 3 || text[0] == "#") begin
                    continue;
                end
                n_fields = $sscanf(text, "%s %d %h", cmd, arg, expv);
                if (n_fields != 3) begin
                    errors++;
                    $display("data line %0d could not be parsed", line_no);
                    continue;
                end
                cmd_q.push_back(cmd);
                arg_q.push_back(arg);
                exp_q.push_back(expv);
                line_q.push_back(line_no);
            end
            $fclose(fd);
            // 64 per line plus 12 per key or drop pulse, plus margin
            cycle_limit = 200 + 64 * cmd_q.size();
            foreach (cmd_q[i]) begin
                if (cmd_q[i] == "tick" || cmd_q[i] == "left" || cmd_q[i] == "right" ||
                    cmd_q[i] == "rotate" || cmd_q[i] == "start") begin
                    cycle_limit += 12 * arg_q[i];
                end
            end
            wait (reset == 1'b0);
            @(posedge clk);
            foreach (cmd_q[i]) begin
                name = $sformatf("line %0d %s %0d", line_q[i], cmd_q[i], arg_q[i]);
                case (cmd_q[i])
                    "start":  pulse(3, arg_q[i]);
                    "left":   pulse(0, arg_q[i]);
                    "right":  pulse(1, arg_q[i]);
                    "rotate": pulse(2, arg_q[i]);
                    "tick":   pulse(4, arg_q[i]);
                    "settle": repeat (64) @(posedge clk);
                    "expect_row": begin
                        // outputs settle after the edge, sample mid cycle
                        @(negedge clk);
                        check(name, exp_q[i], 32'(display[arg_q[i]]));
                    end
                    "expect_score": begin
                        @(negedge clk);
                        check(name, exp_q[i], 32'(score));
                    end
                    "expect_gameover": begin
                        @(negedge clk);
                        check(name, exp_q[i], 32'(gameover));
                    end
                    default: begin
                        errors++;
                        $display("unknown command on data line %0d", line_q[i]);
                    end
                endcase
            end
            $display("checks: %0d  errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

/* verif/tetris_testdata.txt */
# command argument(decimal) expected(hex)
# argument: presses or drop pulses, or the row for expect_row; row bit c is column c
expect_row 0 000
expect_row 19 000
expect_score 0 00
expect_gameover 0 0
tick 2 0
expect_row 0 000
start 1 0
expect_row 0 008
expect_row 3 008
expect_row 4 000
tick 1 0
expect_row 0 000
expect_row 4 008
left 1 0
expect_row 1 004
left 3 0
expect_row 1 001
rotate 1 0
expect_row 1 00f
expect_row 2 000
right 7 0
expect_row 1 3c0
left 7 0
expect_row 1 00f
tick 18 0
settle 0 0
expect_row 19 00f
expect_row 0 018
rotate 1 0
expect_row 0 018
expect_row 1 018
left 3 0
expect_row 1 003
tick 17 0
settle 0 0
expect_row 17 003
left 3 0
tick 15 0
settle 0 0
left 2 0
tick 13 0
settle 0 0
expect_row 13 006
right 1 0
tick 18 0
settle 0 0
expect_row 19 07f
expect_score 0 00
right 4 0
tick 18 0
settle 0 0
expect_score 0 01
expect_row 19 213
expect_row 18 003
expect_row 0 010
tick 13 0
settle 0 0
expect_row 14 03e
tick 10 0
settle 0 0
expect_row 10 008
tick 8 0
settle 0 0
tick 6 0
settle 0 0
tick 4 0
settle 0 0
tick 2 0
settle 0 0
settle 0 0
expect_gameover 0 1
expect_row 0 020
expect_row 1 038
left 1 0
start 1 0
tick 2 0
expect_gameover 0 1
expect_row 0 020
expect_row 1 038
expect_score 0 01

/* all.f */
hdl/tetris_pkg.sv
hdl/key_strobe.sv
hdl/piece_rom.sv
hdl/piece_fit.sv
hdl/line_clear.sv
hdl/tetris_game.sv
verif/tb_clock.sv
verif/tb_tetris.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tetris
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
DATA := verif/tetris_testdata.txt
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q '^Everything OK$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
